// ==== mem_pkg.sv ====
// Shared widths, controller states and bus structs for the cache memory system, imported by every module
package mem_pkg;

   // Byte address split, bit 0 unused
   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 16;
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int OFFSET_W       = 2;
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_LINES      = 1 << INDEX_W;

   // Main memory geometry and timing
   localparam int NUM_BANKS  = 4;
   localparam int BANK_SEL_W = $clog2(NUM_BANKS);
   localparam int MEM_RD_LAT = 2;
   localparam int BANK_BUSY  = 4;
   localparam int BUSY_W     = $clog2(BANK_BUSY + 1);
   localparam int MEM_WORDS  = 32768;
   localparam int MEM_ADDR_W = $clog2(MEM_WORDS);
   localparam int BANK_DEPTH = MEM_WORDS / NUM_BANKS;

   // Miss handling FSM
   typedef enum logic [2:0] {
      IDLE,
      COMPRD,
      COMPWR,
      WBMEM,
      MEMRD,
      WAITSTATE,
      INSTALL,
      ERR
   } ctrl_state_e;

   // Controller to cache
   typedef struct packed {
      logic                enable;
      logic                comp;
      logic                write;
      logic                valid_in;
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
      logic [DATA_W-1:0]   data;
   } cache_req_t;

   // Cache to controller
   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [TAG_W-1:0]  tag_out;
      logic [DATA_W-1:0] data;
   } cache_rsp_t;

   // Controller to memory, word addressed
   typedef struct packed {
      logic [MEM_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
      logic                  wr;
      logic                  rd;
   } mem_req_t;

   // Memory to controller
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              stall;
   } mem_rsp_t;

endpackage

// ==== cache_array.sv ====
// Direct-mapped line storage with tag compare; driven by the controller through cache_req_t
`timescale 1ns/10ps

module cache_array
   import mem_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  cache_req_t req,
   output cache_rsp_t rsp
);

   // Per-line state bits
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // Line payload
   logic [TAG_W-1:0]  tag_q  [NUM_LINES];
   logic [DATA_W-1:0] data_q [NUM_LINES][WORDS_PER_LINE];

   logic tag_match;
   logic wr_hit;
   logic wr_fill;

   assign tag_match = tag_q[req.index] == req.tag;

   // Compare write lands only on a valid matching line
   assign wr_hit = req.enable && req.write && req.comp &&
                   valid_q[req.index] && tag_match;

   // Fill write from the refill path, no compare
   assign wr_fill = req.enable && req.write && !req.comp;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_fill) begin
         valid_q[req.index] <= req.valid_in;
         // Freshly installed words match memory
         dirty_q[req.index] <= 1'b0;
      end else if (wr_hit) begin
         dirty_q[req.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fill) begin
         tag_q[req.index] <= req.tag;
      end
      if (wr_fill || wr_hit) begin
         data_q[req.index][req.offset] <= req.data;
      end
   end

   // Combinational read of the indexed line
   always_comb begin
      rsp.hit     = req.enable && tag_match;
      rsp.valid   = req.enable && valid_q[req.index];
      rsp.dirty   = req.enable && dirty_q[req.index];
      rsp.tag_out = tag_q[req.index];
      rsp.data    = data_q[req.index][req.offset];
   end

   // Offset picks the word on both reads and writes
   a_offset_known: assert property (@(posedge clk) disable iff (rst)
      req.enable |-> !$isunknown(req.offset));

endmodule

// ==== bank_mem.sv ====
// Four-bank word memory with fixed read latency and per-bank busy time; serves cache misses
`timescale 1ns/10ps

module bank_mem
   import mem_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req,
   output mem_rsp_t rsp
);

   // One slot of the read delay line
   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
   } rd_slot_t;

   // Bank storage, all zero at start
   logic [DATA_W-1:0] words [NUM_BANKS][BANK_DEPTH] = '{default: '0};

   logic [BUSY_W-1:0] busy_q  [NUM_BANKS];
   rd_slot_t          rd_pipe [MEM_RD_LAT];

   logic [BANK_SEL_W-1:0]            bank;
   logic [MEM_ADDR_W-BANK_SEL_W-1:0] row;
   logic                             accept;

   // Low word bits pick the bank, so a line spreads over all four
   assign bank = req.addr[BANK_SEL_W-1:0];
   assign row  = req.addr[MEM_ADDR_W-1:BANK_SEL_W];

   assign rsp.stall = (req.rd || req.wr) && (busy_q[bank] != '0);
   assign accept    = (req.rd || req.wr) && !rsp.stall;

   // Busy countdown per bank
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && bank == BANK_SEL_W'(b)) begin
               busy_q[b] <= BUSY_W'(BANK_BUSY);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
      end
   end

   // Write lands at the accepting edge
   always @(posedge clk) begin
      if (accept && req.wr) begin
         words[bank][row] <= req.data;
      end
   end

   // Read delay line
   // Independent slots let reads to other banks overlap
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_RD_LAT; i++) begin
            rd_pipe[i] <= '0;
         end
      end else begin
         rd_pipe[0].valid <= accept && req.rd;
         rd_pipe[0].data  <= words[bank][row];
         for (int i = 1; i < MEM_RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
         end
      end
   end

   // Zero unless a read matures this cycle
   assign rsp.data = rd_pipe[MEM_RD_LAT-1].valid ? rd_pipe[MEM_RD_LAT-1].data : '0;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
      !(req.rd && req.wr));

endmodule

// ==== cache_ctrl.sv ====
// Miss-handling FSM that sequences compare, write-back, refill and retry for the cache memory system
`timescale 1ns/10ps

module cache_ctrl
   import mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] Addr,
   input  logic [DATA_W-1:0] DataIn,
   input  logic              Rd,
   input  logic              Wr,
   input  cache_rsp_t        cache_rsp,
   input  mem_rsp_t          mem_rsp,
   output cache_req_t        cache_req,
   output mem_req_t          mem_req,
   output logic [DATA_W-1:0] DataOut,
   output logic              Done,
   output logic              Stall,
   output logic              CacheHit,
   output logic              err
);

   ctrl_state_e state;
   ctrl_state_e next_state;

   // Word within the line during write-back and refill
   logic [OFFSET_W-1:0] count;
   logic [OFFSET_W-1:0] next_count;

   // Set once the current request has missed
   logic retry;
   logic next_retry;

   logic [TAG_W-1:0]    req_tag;
   logic [INDEX_W-1:0]  req_index;
   logic [OFFSET_W-1:0] req_offset;
   logic                line_hit;
   logic                victim_dirty;
   logic                last_word;

   // Address split, bit 0 dropped
   assign req_offset = Addr[OFFSET_W:1];
   assign req_index  = Addr[OFFSET_W+INDEX_W:OFFSET_W+1];
   assign req_tag    = Addr[ADDR_W-1 -: TAG_W];

   assign line_hit     = cache_rsp.hit && cache_rsp.valid;
   assign victim_dirty = cache_rsp.valid && cache_rsp.dirty;
   assign last_word    = count == OFFSET_W'(WORDS_PER_LINE - 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         count <= '0;
         retry <= 1'b0;
         err   <= 1'b0;
      end else begin
         state <= next_state;
         count <= next_count;
         retry <= next_retry;
         err   <= next_state == ERR;
      end
   end

   always_comb begin
      next_state = state;
      next_count = count;
      next_retry = retry;
      Done       = 1'b0;
      Stall      = 1'b1;

      // Cache idle, pointed at the request word
      cache_req        = '0;
      cache_req.tag    = req_tag;
      cache_req.index  = req_index;
      cache_req.offset = req_offset;
      cache_req.data   = DataIn;

      // Memory idle, pointed at the new line
      mem_req      = '0;
      mem_req.addr = {req_tag, req_index, count};
      mem_req.data = cache_rsp.data;

      case (state)
         IDLE: begin
            Stall      = 1'b0;
            next_retry = 1'b0;
            if (Rd && Wr) begin
               next_state = ERR;
            end else if (Rd) begin
               next_state = COMPRD;
            end else if (Wr) begin
               next_state = COMPWR;
            end
         end

         COMPRD, COMPWR: begin
            cache_req.enable = 1'b1;
            cache_req.comp   = 1'b1;
            cache_req.write  = state == COMPWR;
            if (line_hit) begin
               Done       = 1'b1;
               Stall      = 1'b0;
               next_state = IDLE;
            end else begin
               next_retry = 1'b1;
               // Dirty victim goes back to memory first
               next_state = victim_dirty ? WBMEM : MEMRD;
            end
         end

         WBMEM: begin
            // Victim word to its own address
            cache_req.enable = 1'b1;
            cache_req.offset = count;
            mem_req.wr       = 1'b1;
            mem_req.addr     = {cache_rsp.tag_out, req_index, count};
            if (!mem_rsp.stall) begin
               next_count = count + 1'b1;
               if (last_word) begin
                  next_state = MEMRD;
               end
            end
         end

         MEMRD: begin
            mem_req.rd = 1'b1;
            if (!mem_rsp.stall) begin
               next_state = WAITSTATE;
            end
         end

         // Second cycle of read latency
         WAITSTATE: begin
            next_state = INSTALL;
         end

         INSTALL: begin
            cache_req.enable   = 1'b1;
            cache_req.write    = 1'b1;
            cache_req.valid_in = 1'b1;
            cache_req.offset   = count;
            cache_req.data     = mem_rsp.data;
            next_count         = count + 1'b1;
            if (last_word) begin
               // Back to the original compare, which hits now
               next_state = Wr ? COMPWR : COMPRD;
            end else begin
               next_state = MEMRD;
            end
         end

         // Left only through reset
         ERR: begin
            next_state = ERR;
         end

         default: begin
            next_state = ERR;
         end
      endcase
   end

   assign DataOut  = cache_rsp.data;
   assign CacheHit = Done && !retry;

   // Victim line stays valid and dirty for the whole write-back
   a_victim_held: assert property (@(posedge clk) disable iff (rst)
      (state == WBMEM) |-> (cache_rsp.valid && cache_rsp.dirty));

   // Retried compare hits on the freshly installed line
   a_retry_hits: assert property (@(posedge clk) disable iff (rst)
      (state == INSTALL && last_word) |=> line_hit);

endmodule

// ==== mem_system.sv ====
// Top of the data-memory subsystem joining controller, cache and banked memory for the requester
`timescale 1ns/10ps

module mem_system
   import mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] Addr,
   input  logic [DATA_W-1:0] DataIn,
   input  logic              Rd,
   input  logic              Wr,
   output logic [DATA_W-1:0] DataOut,
   output logic              Done,
   output logic              Stall,
   output logic              CacheHit,
   output logic              err
);

   cache_req_t cache_req;
   cache_rsp_t cache_rsp;
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .Addr      (Addr),
      .DataIn    (DataIn),
      .Rd        (Rd),
      .Wr        (Wr),
      .cache_rsp (cache_rsp),
      .mem_rsp   (mem_rsp),
      .cache_req (cache_req),
      .mem_req   (mem_req),
      .DataOut   (DataOut),
      .Done      (Done),
      .Stall     (Stall),
      .CacheHit  (CacheHit),
      .err       (err)
   );

   cache_array u_cache (
      .clk (clk),
      .rst (rst),
      .req (cache_req),
      .rsp (cache_rsp)
   );

   bank_mem u_mem (
      .clk (clk),
      .rst (rst),
      .req (mem_req),
      .rsp (mem_rsp)
   );

endmodule

// ==== tb_mem_system.sv ====
// Self-checking testbench for mem_system, run as top with directed and random requests
`timescale 1ns/10ps

module tb_mem_system
   import mem_pkg::*;
();

   localparam int NUM_RANDOM   = 300;
   localparam int NUM_DIRECTED = 8;
   localparam int MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * 40 + 200;

   logic              clk = 1'b0;
   logic              rst;
   logic [ADDR_W-1:0] Addr;
   logic [DATA_W-1:0] DataIn;
   logic              Rd;
   logic              Wr;
   logic [DATA_W-1:0] DataOut;
   logic              Done;
   logic              Stall;
   logic              CacheHit;
   logic              err;

   // Reference word memory and per-line tag table
   logic [DATA_W-1:0] ref_mem    [MEM_WORDS];
   logic              line_valid [NUM_LINES];
   logic [TAG_W-1:0]  line_tag   [NUM_LINES];

   // Expectations for the current request, read by the monitor
   string             exp_name;
   logic [DATA_W-1:0] exp_data;
   logic              exp_hit;
   logic              exp_read;
   logic              req_active;
   logic              err_test;

   int                cycle_count = 0;
   logic [31:0]       lcg_state;

   // Stimulus scratch
   logic [DATA_W-1:0] got_data;
   logic              got_hit;
   int                got_cycles;
   logic [31:0]       rnd;
   logic [ADDR_W-1:0] rnd_addr;
   logic [DATA_W-1:0] rnd_data;

   mem_system uut (
      .clk      (clk),
      .rst      (rst),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected read data, word address is bits 15:1
   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
      return ref_mem[a[15:1]];
   endfunction

   // Index bits 10:3, tag bits 15:11
   function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
      return line_valid[a[10:3]] && (line_tag[a[10:3]] == a[15:11]);
   endfunction

   // Completed access updates memory and the resident line
   function automatic void update_model(input logic [ADDR_W-1:0] a, input logic wr,
                                        input logic [DATA_W-1:0] d);
      if (wr) begin
         ref_mem[a[15:1]] = d;
      end
      line_valid[a[10:3]] = 1'b1;
      line_tag[a[10:3]]   = a[15:11];
   endfunction

   // All lines invalid, as after reset
   function automatic void clear_table();
      for (int i = 0; i < NUM_LINES; i++) begin
         line_valid[i] = 1'b0;
         line_tag[i]   = '0;
      end
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // One request held until Done, outputs captured in the Done cycle
   task automatic do_access(input string name, input logic [ADDR_W-1:0] a, input logic wr,
                            input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rdata,
                            output logic hit, output int cycles);
      exp_name   = name;
      exp_data   = ref_read(a);
      exp_hit    = predict_hit(a);
      exp_read   = !wr;
      req_active = 1'b1;
      @(posedge clk);
      Addr   <= a;
      DataIn <= d;
      Rd     <= !wr;
      Wr     <= wr;
      cycles = 0;
      @(negedge clk);
      // Count cycles from the first IDLE cycle with the request
      while (!Done) begin
         // Low only in the IDLE cycle that first sees the request
         check_bit({name, " busy stall"}, cycles != 0, Stall);
         cycles++;
         @(negedge clk);
      end
      rdata = DataOut;
      hit   = CacheHit;
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;
      req_active = 1'b0;
      update_model(a, wr, d);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      clear_table();
   endtask

   // Compares every Done cycle against the reference
   always @(negedge clk) begin
      if (!rst) begin
         if (!err_test) begin
            check_bit("err low", 1'b0, err);
         end
         if (Done) begin
            if (!req_active) begin
               stop_run("Done pulsed with no request outstanding");
            end
            check_bit({exp_name, " hit"}, exp_hit, CacheHit);
            check_bit({exp_name, " stall"}, 1'b0, Stall);
            if (exp_read) begin
               check_data({exp_name, " data"}, exp_data, DataOut);
            end
         end
      end
   end

   // Run limit scaled to the request count
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         stop_run("Timeout: requests did not complete within the cycle limit");
      end
   end

   initial begin
      rst        <= 1'b1;
      Addr       <= '0;
      DataIn     <= '0;
      Rd         <= 1'b0;
      Wr         <= 1'b0;
      req_active = 1'b0;
      err_test   = 1'b0;
      exp_name   = "none";
      exp_data   = '0;
      exp_hit    = 1'b0;
      exp_read   = 1'b0;
      lcg_state  = 32'he170;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = '0;
      end
      clear_table();
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      // Cold read returns zero
      do_access("reset read", 16'h1234, 1'b0, '0, got_data, got_hit, got_cycles);
      check_data("reset read data", 16'h0000, got_data);
      check_bit("reset read miss", 1'b0, got_hit);

      // Write then read back
      do_access("write", 16'h0A0C, 1'b1, 16'hBEEF, got_data, got_hit, got_cycles);
      do_access("read back", 16'h0A0C, 1'b0, '0, got_data, got_hit, got_cycles);
      check_data("read back data", 16'hBEEF, got_data);
      check_bit("read back hit", 1'b1, got_hit);

      // Hit latency
      do_access("hit latency", 16'h0A0C, 1'b0, '0, got_data, got_hit, got_cycles);
      check_bit("hit done one cycle later", 1'b1, got_cycles == 1);

      // Dirty victim A (tag 3) evicted by tag 7 at index 0x21
      do_access("conflict write A", 16'h190A, 1'b1, 16'h5A5A, got_data, got_hit, got_cycles);
      do_access("conflict read B", 16'h390C, 1'b0, '0, got_data, got_hit, got_cycles);
      do_access("conflict read A", 16'h190A, 1'b0, '0, got_data, got_hit, got_cycles);
      check_data("write-back data A", 16'h5A5A, got_data);
      check_bit("read A misses", 1'b0, got_hit);

      // Four tags over four indexes
      for (int n = 0; n < NUM_RANDOM; n++) begin
         lcg_state = lcg_next(lcg_state);
         rnd       = lcg_state;
         rnd_addr  = {3'b000, rnd[31:30], 8'h40 + 8'(rnd[29:28]), rnd[27:26], 1'b0};
         lcg_state = lcg_next(lcg_state);
         rnd_data  = lcg_state[31:16];
         do_access($sformatf("random %0d", n), rnd_addr, rnd[25], rnd_data,
                   got_data, got_hit, got_cycles);
      end

      // Rd and Wr together, sticky until reset
      err_test = 1'b1;
      @(posedge clk);
      Addr <= 16'h0200;
      Rd   <= 1'b1;
      Wr   <= 1'b1;
      @(negedge clk);
      repeat (20) begin
         @(negedge clk);
         check_bit("err sticky", 1'b1, err);
      end
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;
      repeat (5) begin
         @(negedge clk);
         check_bit("err after request drop", 1'b1, err);
      end
      apply_reset();
      @(negedge clk);
      check_bit("err cleared by reset", 1'b0, err);
      check_bit("done low after reset", 1'b0, Done);
      check_bit("stall low after reset", 1'b0, Stall);
      err_test = 1'b0;

      $display("Verification passed");
      $finish;
   end

endmodule

// ==== list.f ====
mem_pkg.sv
cache_array.sv
bank_mem.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv
